// ==== hdl/mini_soc_consts.svh ====
`ifndef MINI_SOC_CONSTS_SVH
`define MINI_SOC_CONSTS_SVH

// nmi widths
`define NMI_AW 32
`define NMI_DW 32

// address map with 4 KB regions
`define REGION_BITS 12
`define REGION_MASK 32'h0000_0fff
`define NATV_BASE   32'h1000_0000
`define APB_BASE    32'h2000_0000
`define ERR_RDATA   32'hdead_beef

// native region offsets
`define GPIO_OUT 8'h00
`define GPIO_IN  8'h04
`define GPIO_IE  8'h08
`define GPIO_IS  8'h0c
`define TMR_CTRL 8'h10
`define TMR_CMP  8'h14
`define TMR_CNT  8'h18
`define TMR_CAP  8'h1c
`define TMR_STAT 8'h20

// apb region offsets
`define PWM_CTRL   8'h00
`define PWM_PERIOD 8'h04
`define PWM_DUTY   8'h08
`define PWM_STAT   8'h0c

`define GPIO_W 8
`define IRQ_W  4
`define PWM_W  16

// reset values
`define GPIO_OUT_RST   16'h0000
`define TMR_CMP_RST    32'hffff_ffff
`define PWM_PERIOD_RST 16'd0
`define PWM_DUTY_RST   16'd0

`endif

// ==== hdl/nmi_pkg.sv ====
`include "mini_soc_consts.svh"

package nmi_pkg;

  typedef struct packed {
    logic               valid;
    logic               write;
    logic [`NMI_AW-1:0] addr;
    logic [`NMI_DW-1:0] wdata;
    logic [3:0]         wstrb;
  } nmi_req_t;

  // ready is a single-cycle pulse
  typedef struct packed {
    logic               ready;
    logic               err;
    logic [`NMI_DW-1:0] rdata;
  } nmi_rsp_t;

  typedef enum logic [1:0] {
    REG_NATV,
    REG_APB,
    REG_NONE
  } region_e;

  // expand byte strobes to a bit mask
  function automatic logic [`NMI_DW-1:0] strb_mask(input logic [3:0] strb);
    logic [`NMI_DW-1:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i+:8] = {8{strb[i]}};
    end
    return mask;
  endfunction

endpackage

// ==== hdl/periph_pkg.sv ====
`include "mini_soc_consts.svh"

package periph_pkg;

  // word index within the native region
  typedef enum logic [3:0] {
    SEL_GPIO_OUT = 4'(`GPIO_OUT >> 2),
    SEL_GPIO_IN  = 4'(`GPIO_IN >> 2),
    SEL_GPIO_IE  = 4'(`GPIO_IE >> 2),
    SEL_GPIO_IS  = 4'(`GPIO_IS >> 2),
    SEL_TMR_CTRL = 4'(`TMR_CTRL >> 2),
    SEL_TMR_CMP  = 4'(`TMR_CMP >> 2),
    SEL_TMR_CNT  = 4'(`TMR_CNT >> 2),
    SEL_TMR_CAP  = 4'(`TMR_CAP >> 2),
    SEL_TMR_STAT = 4'(`TMR_STAT >> 2)
  } natv_reg_e;

  // word index within the apb region
  typedef enum logic [1:0] {
    SEL_PWM_CTRL   = 2'(`PWM_CTRL >> 2),
    SEL_PWM_PERIOD = 2'(`PWM_PERIOD >> 2),
    SEL_PWM_DUTY   = 2'(`PWM_DUTY >> 2),
    SEL_PWM_STAT   = 2'(`PWM_STAT >> 2)
  } pwm_reg_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  typedef struct packed {
    logic [`GPIO_W-1:0] oe;
    logic [`GPIO_W-1:0] out;
  } gpio_pins_t;

endpackage

// ==== hdl/nmi_bus.sv ====
`timescale 1ns/1ns
`include "mini_soc_consts.svh"

module nmi_bus (
  input  logic              clk_i,
  input  logic              reset_i,
  input  nmi_pkg::nmi_req_t m_req_i,
  output nmi_pkg::nmi_rsp_t m_rsp_o,
  output nmi_pkg::nmi_req_t natv_req_o,
  input  nmi_pkg::nmi_rsp_t natv_rsp_i,
  output nmi_pkg::nmi_req_t apb_req_o,
  input  nmi_pkg::nmi_rsp_t apb_rsp_i
);
  import nmi_pkg::*;

  region_e dec_region;
  region_e region_q;
  region_e cur_region;
  logic    busy_q;

  // decode on the top address bits
  always_comb begin
    if ((m_req_i.addr & ~`REGION_MASK) == `NATV_BASE) begin
      dec_region = REG_NATV;
    end else if ((m_req_i.addr & ~`REGION_MASK) == `APB_BASE) begin
      dec_region = REG_APB;
    end else begin
      dec_region = REG_NONE;
    end
  end

  // region held while a transfer is open
  assign cur_region = busy_q ? region_q : dec_region;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q   <= 1'b0;
      region_q <= REG_NONE;
    end else begin
      busy_q <= m_req_i.valid & ~m_rsp_o.ready;
      if (!busy_q) begin
        region_q <= dec_region;
      end
    end
  end

  always_comb begin
    natv_req_o       = m_req_i;
    apb_req_o        = m_req_i;
    natv_req_o.valid = m_req_i.valid && (cur_region == REG_NATV);
    apb_req_o.valid  = m_req_i.valid && (cur_region == REG_APB);
  end

  always_comb begin
    case (cur_region)
      REG_NATV: m_rsp_o = natv_rsp_i;
      REG_APB:  m_rsp_o = apb_rsp_i;
      default: begin
        // unmapped, answer on the second cycle
        m_rsp_o.ready = busy_q & m_req_i.valid;
        m_rsp_o.err   = busy_q & m_req_i.valid;
        m_rsp_o.rdata = `ERR_RDATA;
      end
    endcase
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      m_req_i.valid && !m_rsp_o.ready |=> $stable(m_req_i))
    else $error("nmi request changed before ready");

endmodule

// ==== hdl/natv_periph.sv ====
`timescale 1ns/1ns
`include "mini_soc_consts.svh"

module natv_periph (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  nmi_pkg::nmi_req_t      req_i,
  output nmi_pkg::nmi_rsp_t      rsp_o,
  input  logic [`GPIO_W-1:0]     gpio_i,
  output periph_pkg::gpio_pins_t gpio_o,
  input  logic                   tmr_capch_i,
  output logic [1:0]             irq_o
);
  import nmi_pkg::*;
  import periph_pkg::*;

  logic                  rdy_q;
  logic                  err_q;
  logic [`NMI_DW-1:0]    rdata_q;
  logic                  accept;
  logic                  wr_en;
  natv_reg_e             sel;
  logic                  hit;
  logic [`NMI_DW-1:0]    rd_val;
  logic [`NMI_DW-1:0]    wmask;
  logic [`NMI_DW-1:0]    wval;
  logic [`NMI_DW-1:0]    clr_bits;
  logic [2*`GPIO_W-1:0]  gpio_out_q;
  logic [`GPIO_W-1:0]    gpio_ie_q;
  logic [`GPIO_W-1:0]    gpio_is_q;
  logic [`GPIO_W-1:0]    gpio_s1_q;
  logic [`GPIO_W-1:0]    gpio_s2_q;
  logic [`GPIO_W-1:0]    gpio_d_q;
  logic [`GPIO_W-1:0]    gpio_rise;
  logic                  tmr_en_q;
  logic [`NMI_DW-1:0]    tmr_cmp_q;
  logic [`NMI_DW-1:0]    tmr_cnt_q;
  logic [`NMI_DW-1:0]    tmr_cap_q;
  logic                  tmr_stat_q;
  logic                  tmr_hit;
  logic [2:0]            cap_sync_q;
  logic                  cap_rise;

  // accepted in the first valid cycle, answered in the next
  assign accept   = req_i.valid & ~rdy_q;
  assign wr_en    = accept & req_i.write & hit;
  assign sel      = natv_reg_e'(req_i.addr[5:2]);
  assign wmask    = strb_mask(req_i.wstrb);
  assign wval     = (rd_val & ~wmask) | (req_i.wdata & wmask);
  assign clr_bits = req_i.wdata & wmask;

  always_comb begin
    hit    = (req_i.addr[`REGION_BITS-1:6] == '0);
    rd_val = '0;
    case (sel)
      SEL_GPIO_OUT: rd_val[2*`GPIO_W-1:0] = gpio_out_q;
      SEL_GPIO_IN:  rd_val[`GPIO_W-1:0] = gpio_s2_q;
      SEL_GPIO_IE:  rd_val[`GPIO_W-1:0] = gpio_ie_q;
      SEL_GPIO_IS:  rd_val[`GPIO_W-1:0] = gpio_is_q;
      SEL_TMR_CTRL: rd_val[0] = tmr_en_q;
      SEL_TMR_CMP:  rd_val = tmr_cmp_q;
      SEL_TMR_CNT:  rd_val = tmr_cnt_q;
      SEL_TMR_CAP:  rd_val = tmr_cap_q;
      SEL_TMR_STAT: rd_val[0] = tmr_stat_q;
      default:      hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdy_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      rdy_q <= accept;
      err_q <= accept & ~hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_val;
    end
  end

  assign rsp_o = '{ready: rdy_q, err: err_q, rdata: rdata_q};

  // pin and capture synchronizers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_s1_q  <= '0;
      gpio_s2_q  <= '0;
      gpio_d_q   <= '0;
      cap_sync_q <= '0;
    end else begin
      gpio_s1_q  <= gpio_i;
      gpio_s2_q  <= gpio_s1_q;
      gpio_d_q   <= gpio_s2_q;
      cap_sync_q <= {cap_sync_q[1:0], tmr_capch_i};
    end
  end

  assign gpio_rise = gpio_s2_q & ~gpio_d_q;
  assign cap_rise  = cap_sync_q[1] & ~cap_sync_q[2];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q <= `GPIO_OUT_RST;
      gpio_ie_q  <= '0;
      gpio_is_q  <= '0;
    end else begin
      if (wr_en && sel == SEL_GPIO_OUT) begin
        gpio_out_q <= wval[2*`GPIO_W-1:0];
      end
      if (wr_en && sel == SEL_GPIO_IE) begin
        gpio_ie_q <= wval[`GPIO_W-1:0];
      end
      // new edges win over a clear in the same cycle
      if (wr_en && sel == SEL_GPIO_IS) begin
        gpio_is_q <= (gpio_is_q & ~clr_bits[`GPIO_W-1:0]) | (gpio_rise & gpio_ie_q);
      end else begin
        gpio_is_q <= gpio_is_q | (gpio_rise & gpio_ie_q);
      end
    end
  end

  assign tmr_hit = tmr_en_q && (tmr_cnt_q == tmr_cmp_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tmr_en_q   <= 1'b0;
      tmr_cmp_q  <= `TMR_CMP_RST;
      tmr_cnt_q  <= '0;
      tmr_stat_q <= 1'b0;
    end else begin
      if (wr_en && sel == SEL_TMR_CTRL) begin
        tmr_en_q <= wval[0];
      end
      if (wr_en && sel == SEL_TMR_CMP) begin
        tmr_cmp_q <= wval;
      end
      if (wr_en && sel == SEL_TMR_CNT) begin
        tmr_cnt_q <= wval;
      end else if (tmr_hit) begin
        tmr_cnt_q <= '0;
      end else if (tmr_en_q) begin
        tmr_cnt_q <= tmr_cnt_q + 1'b1;
      end
      if (tmr_hit) begin
        tmr_stat_q <= 1'b1;
      end else if (wr_en && sel == SEL_TMR_STAT && clr_bits[0]) begin
        tmr_stat_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_rise) begin
      tmr_cap_q <= tmr_cnt_q;
    end
  end

  assign gpio_o = '{oe: gpio_out_q[2*`GPIO_W-1:`GPIO_W], out: gpio_out_q[`GPIO_W-1:0]};
  assign irq_o  = {tmr_stat_q, |gpio_is_q};

  a_rdy_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_o.ready |=> !rsp_o.ready)
    else $error("native ready held for two cycles");

endmodule

// ==== hdl/apb_pwm_periph.sv ====
`timescale 1ns/1ns
`include "mini_soc_consts.svh"

module apb_pwm_periph (
  input  logic              clk_i,
  input  logic              reset_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o,
  output logic              pwm_o,
  output logic              irq_o
);
  import nmi_pkg::*;
  import periph_pkg::*;

  apb_state_e              state_q;
  apb_state_e              state_n;
  // internal apb side
  logic                    psel;
  logic                    penable;
  logic                    pwrite_q;
  logic [`REGION_BITS-1:0] paddr_q;
  logic [`NMI_DW-1:0]      pwdata_q;
  logic [3:0]              pstrb_q;
  logic [`NMI_DW-1:0]      prdata;
  logic                    pslverr;
  pwm_reg_e                sel;
  logic                    hit;
  logic                    wr_en;
  logic [`NMI_DW-1:0]      wmask;
  logic [`NMI_DW-1:0]      wval;
  logic                    pwm_en_q;
  logic [`PWM_W-1:0]       period_q;
  logic [`PWM_W-1:0]       duty_q;
  logic [`PWM_W-1:0]       cnt_q;
  logic                    stat_q;
  logic                    wrap;

  always_comb begin
    state_n = state_q;
    case (state_q)
      APB_IDLE: begin
        if (req_i.valid) begin
          state_n = APB_SETUP;
        end
      end
      APB_SETUP:  state_n = APB_ACCESS;
      APB_ACCESS: state_n = APB_IDLE;
      default:    state_n = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= APB_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  // capture the request for the setup phase
  always_ff @(posedge clk_i) begin
    if (state_q == APB_IDLE && req_i.valid) begin
      pwrite_q <= req_i.write;
      paddr_q  <= req_i.addr[`REGION_BITS-1:0];
      pwdata_q <= req_i.wdata;
      pstrb_q  <= req_i.wstrb;
    end
  end

  assign psel    = (state_q != APB_IDLE);
  assign penable = (state_q == APB_ACCESS);
  assign sel     = pwm_reg_e'(paddr_q[3:2]);
  assign hit     = (paddr_q[`REGION_BITS-1:4] == '0);
  assign wr_en   = psel & penable & pwrite_q & hit;
  assign pslverr = penable & ~hit;
  assign wmask   = strb_mask(pstrb_q);
  assign wval    = (prdata & ~wmask) | (pwdata_q & wmask);

  always_comb begin
    prdata = '0;
    case (sel)
      SEL_PWM_CTRL:   prdata[0] = pwm_en_q;
      SEL_PWM_PERIOD: prdata[`PWM_W-1:0] = period_q;
      SEL_PWM_DUTY:   prdata[`PWM_W-1:0] = duty_q;
      default:        prdata[0] = stat_q;
    endcase
  end

  assign rsp_o = '{ready: penable, err: pslverr, rdata: prdata};

  // last count of the period
  assign wrap = pwm_en_q && ({1'b0, cnt_q} + 1'b1 >= {1'b0, period_q});

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pwm_en_q <= 1'b0;
      period_q <= `PWM_PERIOD_RST;
      duty_q   <= `PWM_DUTY_RST;
      cnt_q    <= '0;
      stat_q   <= 1'b0;
    end else begin
      if (wr_en && sel == SEL_PWM_CTRL) begin
        pwm_en_q <= wval[0];
      end
      if (wr_en && sel == SEL_PWM_PERIOD) begin
        period_q <= wval[`PWM_W-1:0];
      end
      if (wr_en && sel == SEL_PWM_DUTY) begin
        duty_q <= wval[`PWM_W-1:0];
      end
      if (!pwm_en_q || wrap) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (wrap) begin
        stat_q <= 1'b1;
      end else if (wr_en && sel == SEL_PWM_STAT && pwdata_q[0] && wmask[0]) begin
        stat_q <= 1'b0;
      end
    end
  end

  assign pwm_o = pwm_en_q & (cnt_q < duty_q);
  assign irq_o = stat_q;

  a_access_once: assert property (@(posedge clk_i) disable iff (reset_i)
      state_q == APB_ACCESS |=> state_q != APB_ACCESS)
    else $error("apb access phase repeated");

endmodule

// ==== hdl/mini_soc.sv ====
`timescale 1ns/1ns
`include "mini_soc_consts.svh"

module mini_soc (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  nmi_pkg::nmi_req_t      m_req_i,
  output nmi_pkg::nmi_rsp_t      m_rsp_o,
  input  logic [`GPIO_W-1:0]     gpio_i,
  output periph_pkg::gpio_pins_t gpio_o,
  input  logic                   tmr_capch_i,
  input  logic                   extn_irq_i,
  output logic                   pwm_o,
  output logic [`IRQ_W-1:0]      irq_o
);
  import nmi_pkg::*;

  nmi_req_t   natv_req;
  nmi_rsp_t   natv_rsp;
  nmi_req_t   apb_req;
  nmi_rsp_t   apb_rsp;
  logic [1:0] natv_irq;
  logic       pwm_irq;

  // gpio, timer, pwm, external
  assign irq_o = {extn_irq_i, pwm_irq, natv_irq};

  nmi_bus u_bus (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .m_req_i   (m_req_i),
    .m_rsp_o   (m_rsp_o),
    .natv_req_o(natv_req),
    .natv_rsp_i(natv_rsp),
    .apb_req_o (apb_req),
    .apb_rsp_i (apb_rsp)
  );

  natv_periph u_natv_periph (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (natv_req),
    .rsp_o      (natv_rsp),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .tmr_capch_i(tmr_capch_i),
    .irq_o      (natv_irq)
  );

  apb_pwm_periph u_apb_pwm_periph (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .req_i  (apb_req),
    .rsp_o  (apb_rsp),
    .pwm_o  (pwm_o),
    .irq_o  (pwm_irq)
  );

endmodule

// ==== verif/mini_soc_tb.sv ====
`timescale 1ns/1ns
`include "mini_soc_consts.svh"

module mini_soc_tb;
  import nmi_pkg::*;
  import periph_pkg::*;

  typedef enum {OP_WR, OP_RD, OP_RDLE, OP_PIN, OP_CAP, OP_WAIT, OP_IRQ, OP_OUT, OP_PWM,
                OP_BAD} op_e;

  localparam string DATA_FILE = "verif/mini_soc_testdata.txt";
  localparam int CYCLES_PER_STEP = 200;

  logic             clk = 1'b0;
  logic             reset;
  nmi_req_t         m_req;
  nmi_rsp_t         m_rsp;
  logic [7:0]       gpio_in;
  gpio_pins_t       gpio_out;
  logic             tmr_capch;
  logic             extn_irq;
  logic             pwm;
  logic [3:0]       irq;

  op_e              step_op[$];
  logic [31:0]      step_addr[$];
  logic [31:0]      step_data[$];
  logic [31:0]      step_exp[$];
  string            step_name[$];
  int               n_steps = 0;
  int               cur_step = 0;
  int               err_count = 0;
  int               check_count = 0;
  int               test_count = 0;
  int               test_fail = 0;
  int               test_errs = 0;
  string            cur_test = "";
  logic             waiting_ready = 1'b0;

  mini_soc dut0 (
    .clk_i      (clk),
    .reset_i    (reset),
    .m_req_i    (m_req),
    .m_rsp_o    (m_rsp),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .tmr_capch_i(tmr_capch),
    .extn_irq_i (extn_irq),
    .pwm_o      (pwm),
    .irq_o      (irq)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic op_e parse_op(input string s);
    case (s)
      "WR":    return OP_WR;
      "RD":    return OP_RD;
      "RDLE":  return OP_RDLE;
      "PIN":   return OP_PIN;
      "CAP":   return OP_CAP;
      "WAIT":  return OP_WAIT;
      "IRQ":   return OP_IRQ;
      "OUT":   return OP_OUT;
      "PWM":   return OP_PWM;
      default: return OP_BAD;
    endcase
  endfunction

  // anything outside the two 4 KB regions gets an error response
  function automatic logic unmapped(input logic [31:0] addr);
    logic [31:0] base;
    base = addr & ~`REGION_MASK;
    return (base != `NATV_BASE) && (base != `APB_BASE);
  endfunction

  task automatic load_steps(output int count);
    int          fd;
    int          n;
    string       line;
    string       op_s;
    string       nm;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    count = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", DATA_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %h %h %h %s", op_s, a, d, e, nm);
      if (n != 5) begin
        continue;
      end
      if (parse_op(op_s) == OP_BAD) begin
        $display("unknown opcode %s in %s", op_s, DATA_FILE);
        err_count++;
        continue;
      end
      step_op.push_back(parse_op(op_s));
      step_addr.push_back(a);
      step_data.push_back(d);
      step_exp.push_back(e);
      step_name.push_back(nm);
      count++;
    end
    $fclose(fd);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic close_test();
    if (cur_test != "") begin
      test_count++;
      if (test_errs != 0) begin
        test_fail++;
        $display("FAIL %s (%0d errors)", cur_test, test_errs);
      end else begin
        $display("ok   %s", cur_test);
      end
    end
    test_errs = 0;
  endtask

  // valid stays up through the edge where ready is seen
  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    m_req.valid   = 1'b1;
    m_req.write   = write;
    m_req.addr    = addr;
    m_req.wdata   = wdata;
    m_req.wstrb   = 4'hf;
    waiting_ready = 1'b1;
    @(negedge clk);
    while (!m_rsp.ready) begin
      @(negedge clk);
    end
    rdata         = m_rsp.rdata;
    err           = m_rsp.err;
    waiting_ready = 1'b0;
    @(negedge clk);
    m_req.valid = 1'b0;
  endtask

  task automatic run_step(input int i);
    logic [31:0] rdata;
    logic [31:0] rnd;
    logic [7:0]  mask;
    logic        err;
    logic        in_range;
    int          highs;
    if (step_name[i] != cur_test) begin
      close_test();
      cur_test = step_name[i];
    end
    case (step_op[i])
      OP_WR: begin
        bus_access(1'b1, step_addr[i], step_data[i], rdata, err);
        check_value({step_name[i], " err"}, {31'b0, unmapped(step_addr[i])}, {31'b0, err});
      end
      OP_RD: begin
        bus_access(1'b0, step_addr[i], 32'h0, rdata, err);
        check_value(step_name[i], step_exp[i], rdata);
        check_value({step_name[i], " err"}, {31'b0, unmapped(step_addr[i])}, {31'b0, err});
      end
      OP_RDLE: begin
        bus_access(1'b0, step_addr[i], 32'h0, rdata, err);
        // value has to lie in 1..expect
        in_range = (rdata != 32'h0) && (rdata <= step_exp[i]);
        check_value({step_name[i], " in range"}, 32'h1, {31'b0, in_range});
        check_value({step_name[i], " err"}, {31'b0, unmapped(step_addr[i])}, {31'b0, err});
      end
      OP_PIN: begin
        rnd     = $urandom();
        mask    = step_addr[i][7:0];
        gpio_in = (step_data[i][7:0] & ~mask) | (rnd[7:0] & mask);
      end
      OP_CAP: begin
        tmr_capch = 1'b1;
        @(negedge clk);
        tmr_capch = 1'b0;
      end
      OP_WAIT: begin
        repeat (step_data[i]) @(negedge clk);
      end
      OP_IRQ: begin
        extn_irq = step_data[i][0];
        @(negedge clk);
        check_value(step_name[i], step_exp[i], {28'b0, irq});
      end
      OP_OUT: begin
        check_value(step_name[i], step_exp[i], {16'b0, gpio_out});
      end
      OP_PWM: begin
        highs = 0;
        repeat (step_data[i]) begin
          @(negedge clk);
          if (pwm) begin
            highs++;
          end
        end
        check_value(step_name[i], step_exp[i], highs);
      end
      default: begin
        $display("step %0d has no handler", i);
        err_count++;
      end
    endcase
  endtask

  // run limit scales with the number of steps
  initial begin
    wait (n_steps > 0);
    repeat (n_steps * CYCLES_PER_STEP) @(posedge clk);
    if (waiting_ready) begin
      $display("timeout: the DUT never answered the bus request of step %0d (%s)",
               cur_step, cur_test);
    end else begin
      $display("timeout: the run exceeded %0d cycles", n_steps * CYCLES_PER_STEP);
    end
    $display("Test failures found");
    $finish;
  end

  initial begin
    int count;
    reset     = 1'b1;
    m_req     = '0;
    gpio_in   = '0;
    tmr_capch = 1'b0;
    extn_irq  = 1'b0;
    void'($urandom(27));
    load_steps(count);
    repeat (10) @(negedge clk);
    reset = 1'b0;
    if (count == 0) begin
      $display("no steps could be read from %s", DATA_FILE);
      err_count++;
    end else begin
      n_steps = count;
      for (int i = 0; i < count; i++) begin
        cur_step = i;
        run_step(i);
      end
      close_test();
    end
    $display("tests: %0d run, %0d failed; checks: %0d; errors: %0d",
             test_count, test_fail, check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== mini_soc.f ====
+incdir+hdl
hdl/nmi_pkg.sv
hdl/periph_pkg.sv
hdl/nmi_bus.sv
hdl/natv_periph.sv
hdl/apb_pwm_periph.sv
hdl/mini_soc.sv
verif/mini_soc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mini_soc testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
  --top-module mini_soc_tb \
  -f mini_soc.f \
  -Mdir obj_dir -o mini_soc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mini_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// ==== verif/mini_soc_testdata.txt ====
# op addr data expect name, all numbers hex; PIN addr = pins given random values
# WAIT/PWM data = cycle count; IRQ data drives extn_irq_i; RDLE passes if 0 < rdata <= expect
WR   10000000 0000a55a 00000000 gpio_out
RD   10000000 00000000 0000a55a gpio_out
OUT  00000000 00000000 0000a55a gpio_out
PIN  00000000 0000005a 00000000 gpio_in
WAIT 00000000 00000003 00000000 gpio_in
RD   10000004 00000000 0000005a gpio_in
WR   10000008 00000001 00000000 gpio_irq
PIN  000000fe 00000000 00000000 gpio_irq
WAIT 00000000 00000004 00000000 gpio_irq
PIN  000000fe 00000001 00000000 gpio_irq
WAIT 00000000 00000004 00000000 gpio_irq
RD   1000000c 00000000 00000001 gpio_irq
IRQ  00000000 00000000 00000001 gpio_irq
WR   1000000c 00000001 00000000 gpio_irq_clear
RD   1000000c 00000000 00000000 gpio_irq_clear
IRQ  00000000 00000000 00000000 gpio_irq_clear
PIN  00000000 00000001 00000000 gpio_masked
WAIT 00000000 00000004 00000000 gpio_masked
PIN  00000000 00000081 00000000 gpio_masked
WAIT 00000000 00000004 00000000 gpio_masked
RD   1000000c 00000000 00000000 gpio_masked
WR   10000014 00000014 00000000 timer_cmp
WR   10000010 00000001 00000000 timer_cmp
WAIT 00000000 00000032 00000000 timer_cmp
RD   10000020 00000000 00000001 timer_cmp
IRQ  00000000 00000000 00000002 timer_cmp
CAP  00000000 00000000 00000000 timer_cap
WAIT 00000000 00000004 00000000 timer_cap
RDLE 1000001c 00000000 00000014 timer_cap
WR   10000010 00000000 00000000 timer_clear
WR   10000020 00000001 00000000 timer_clear
RD   10000020 00000000 00000000 timer_clear
IRQ  00000000 00000000 00000000 timer_clear
WR   20000004 0000000a 00000000 pwm_regs
WR   20000008 00000004 00000000 pwm_regs
WR   20000000 00000001 00000000 pwm_regs
RD   20000004 00000000 0000000a pwm_regs
RD   20000008 00000000 00000004 pwm_regs
RD   20000000 00000000 00000001 pwm_regs
PWM  00000000 0000000a 00000004 pwm_duty
IRQ  00000000 00000000 00000004 pwm_irq
RD   30000000 00000000 deadbeef bus_unmapped
RD   10000000 00000000 0000a55a bus_recover
IRQ  00000000 00000001 0000000c extn_irq
